/* project.f */
+incdir+source
source/bridge_pkg.sv
source/mem_req_if.sv
source/burst_fifo.sv
source/burst_ctrl.sv
source/axi_write_channel.sv
source/axi_read_channel.sv
source/mem_axi3_bridge.sv
sim/axi3_slave_model.sv
sim/tb_mem_axi3_bridge.sv

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_mem_axi3_bridge \
    -Mdir obj_dir -o sim_bridge &&
output=$(./obj_dir/sim_bridge 2>&1)
status=$?
echo "$output"
[ "$status" -eq 0 ] && echo "$output" | grep -q "RESULT: PASS" && exit 0 || exit 1

/* sim/axi3_slave_model.sv */
/*
 * AXI3 slave model
 * Word memory with random ready stalls and INCR burst read responses
 */
`timescale 1ns/1ns
`include "bridge_params.svh"

module axi3_slave_model (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   awvalid,
    output logic                   awready,
    input  bridge_pkg::axi_addr_t  awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  bridge_pkg::data_t      wdata,
    input  logic                   wlast,
    input  logic                   arvalid,
    output logic                   arready,
    input  bridge_pkg::axi_addr_t  araddr,
    input  bridge_pkg::burst_len_t arlen,
    output logic                   rvalid,
    output bridge_pkg::data_t      rdata,
    output logic                   rlast
);
    bridge_pkg::data_t mem [1024];
    logic [9:0]        aw_idx_q [$];
    logic [9:0]        ar_idx_q [$];
    logic [3:0]        ar_len_q [$];
    logic [3:0]        w_beat;
    logic [3:0]        r_beat;

    // Byte address back to a word index
    function automatic logic [9:0] word_index(bridge_pkg::axi_addr_t a);
        bridge_pkg::axi_addr_t off;
        off = a - `BRIDGE_BASE_ADDR;
        return off[11:2];
    endfunction

    function automatic bridge_pkg::data_t fill_word(int unsigned i);
        return 32'hC3A5_0000 ^ (i * 32'h0001_0421) ^ (i << 22);
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(i);
        end
        awready = 1'b0;
        wready  = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        w_beat  = '0;
        r_beat  = '0;
        forever begin
            // Handshakes are settled by mid cycle
            @(negedge clk);
            if (!srst) begin
                if (awvalid && awready) begin
                    aw_idx_q.push_back(word_index(awaddr));
                end
                if (wvalid && wready && aw_idx_q.size() > 0) begin
                    mem[aw_idx_q[0] + w_beat] = wdata;
                    w_beat = w_beat + 1'b1;
                    if (wlast) begin
                        w_beat = '0;
                        void'(aw_idx_q.pop_front());
                    end
                end
                if (arvalid && arready) begin
                    ar_idx_q.push_back(word_index(araddr));
                    ar_len_q.push_back(arlen);
                end
                if (rvalid) begin
                    r_beat = r_beat + 1'b1;
                    if (rlast) begin
                        r_beat = '0;
                        void'(ar_idx_q.pop_front());
                        void'(ar_len_q.pop_front());
                    end
                end
            end
            @(posedge clk);
            #2;
            awready = !srst && ($urandom % 4 != 0);
            wready  = !srst && ($urandom % 3 != 0);
            arready = !srst && ($urandom % 4 != 0);
            if (!srst && ar_idx_q.size() > 0 && ($urandom % 4 != 0)) begin
                rvalid = 1'b1;
                rdata  = mem[ar_idx_q[0] + r_beat];
                rlast  = (r_beat == ar_len_q[0]);
            end else begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule

/* sim/tb_mem_axi3_bridge.sv */
/*
 * Bridge testbench
 * Random write then read runs against a reference burst grouping model
 */
`timescale 1ns/1ns
`include "bridge_params.svh"

module tb_mem_axi3_bridge;
    localparam int N_WR  = 300;
    localparam int N_RD  = 300;
    localparam int LIMIT = (N_WR + N_RD) * 40;

    logic clk, srst;
    logic wr_req, wr_en, wr_rdy, wr_ack, rd_req, rd_rdy, rd_ack;
    bridge_pkg::word_addr_t wr_addr, rd_addr;
    bridge_pkg::data_t      wr_data, rd_data, wdata, rdata;
    logic awvalid, awready, wvalid, wready, wlast, arvalid, arready, rvalid, rlast;
    bridge_pkg::axi_addr_t  awaddr, araddr;
    bridge_pkg::burst_len_t awlen, arlen;

    // Reference state
    bridge_pkg::data_t       model_mem [1024];
    bridge_pkg::data_t       w_data_q [$];
    bridge_pkg::data_t       rd_data_q [$];
    bridge_pkg::burst_ctxt_t aw_q [$];
    bridge_pkg::burst_ctxt_t ar_q [$];
    bridge_pkg::burst_len_t  w_len_q [$];
    logic                    run_open [2];
    bridge_pkg::word_addr_t  run_start [2];
    bridge_pkg::word_addr_t  run_next [2];
    bridge_pkg::burst_len_t  run_len [2];
    bridge_pkg::burst_len_t  w_beat;
    int wr_accepted, rd_accepted, ack_count, rd_ack_count, cycles, errors;
    int w_beats, r_beats;

    mem_axi3_bridge dut (.*);

    axi3_slave_model slave (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic stop_with(input string what);
        errors++;
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    function automatic bridge_pkg::axi_addr_t byte_addr(bridge_pkg::burst_ctxt_t c);
        return 32'(`BRIDGE_BASE_ADDR) + {c[13:4], 2'b00};
    endfunction

    // Close the open run of path p into an expected context
    task automatic close_run(input int p);
        bridge_pkg::burst_ctxt_t c;
        c = {run_start[p], run_len[p]};
        if (p == 0) begin
            aw_q.push_back(c);
            w_len_q.push_back(run_len[p]);
        end else begin
            ar_q.push_back(c);
        end
        run_open[p] = 1'b0;
    endtask

    task automatic track_run(input int p, input logic acc, input bridge_pkg::word_addr_t a);
        if (acc && run_open[p] && a == run_next[p] && run_len[p] != 4'd15) begin
            run_len[p]++;
            run_next[p]++;
        end else begin
            if (run_open[p]) begin
                close_run(p);
            end
            if (acc) begin
                run_open[p]  = 1'b1;
                run_start[p] = a;
                run_next[p]  = a + 1'b1;
                run_len[p]   = '0;
            end
        end
    endtask

    // ----------------------------------------
    // Monitor and reference model
    // ----------------------------------------
    always @(negedge clk) begin
        if (!srst) begin
            // Queue room as the controller should see it
            check("wr_rdy", 32'((wr_accepted - w_beats) < `BRIDGE_WDATA_DEPTH), 32'(wr_rdy));
            check("rd_rdy", 32'(ar_q.size() < `BRIDGE_CTXT_DEPTH), 32'(rd_rdy));
            track_run(0, wr_req && wr_en && wr_rdy, wr_addr);
            if (wr_req && wr_en && wr_rdy) begin
                model_mem[wr_addr] = wr_data;
                w_data_q.push_back(wr_data);
                wr_accepted++;
            end
            track_run(1, rd_req && rd_rdy, rd_addr);
            if (rd_req && rd_rdy) begin
                rd_data_q.push_back(model_mem[rd_addr]);
                rd_accepted++;
            end
            if (awvalid && awready) begin
                if (aw_q.size() == 0) stop_with("AW burst issued with no closed write run");
                check("awaddr", byte_addr(aw_q[0]), awaddr);
                check("awlen", 32'(aw_q[0][3:0]), 32'(awlen));
                void'(aw_q.pop_front());
            end
            if (wr_ack) begin
                ack_count++;
            end
            if (wvalid && wready) begin
                if (w_data_q.size() == 0 || w_len_q.size() == 0)
                    stop_with("W beat sent with no accepted write left");
                check("wdata", w_data_q.pop_front(), wdata);
                check("wlast", 32'(w_beat == w_len_q[0]), 32'(wlast));
                if (w_beat == w_len_q[0]) begin
                    w_beat = '0;
                    void'(w_len_q.pop_front());
                end else begin
                    w_beat++;
                end
                w_beats++;
            end
            if (arvalid && arready) begin
                if (ar_q.size() == 0) stop_with("AR burst issued with no closed read run");
                check("araddr", byte_addr(ar_q[0]), araddr);
                check("arlen", 32'(ar_q[0][3:0]), 32'(arlen));
                void'(ar_q.pop_front());
            end
            if (rvalid) begin
                r_beats++;
            end
            if (rd_ack) begin
                if (rd_data_q.size() == 0) stop_with("Read ack with no read outstanding");
                check("rd_data", rd_data_q.pop_front(), rd_data);
                rd_ack_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            stop_with("Timeout: requests did not complete within the cycle limit");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic issue(input logic is_wr, input int count);
        bridge_pkg::word_addr_t a;
        a = 10'($urandom);
        for (int i = 0; i < count; i++) begin
            if ($urandom % 4 == 0) begin
                repeat (1 + $urandom % 3) @(posedge clk);
                #2;
            end
            // Mostly consecutive runs with an occasional jump
            if ($urandom % 6 == 0) a = 10'($urandom);
            else if (i != 0) a = a + 1'b1;
            if (is_wr) begin
                wr_req  = 1'b1;
                wr_en   = 1'b1;
                wr_addr = a;
                wr_data = $urandom;
            end else begin
                rd_req  = 1'b1;
                rd_addr = a;
            end
            // Hold the request until rdy takes it
            do begin
                @(negedge clk);
            end while (is_wr ? !wr_rdy : !rd_rdy);
            @(posedge clk);
            #2;
            wr_req = 1'b0;
            wr_en  = 1'b0;
            rd_req = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(45113));
        srst = 1'b1;
        {wr_req, wr_en, rd_req} = '0;
        wr_addr = '0;
        rd_addr = '0;
        wr_data = '0;
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = 32'hC3A5_0000 ^ (i * 32'h0001_0421) ^ (i << 22);
        end
        run_open = '{1'b0, 1'b0};
        w_beat = '0;
        repeat (4) @(posedge clk);
        #2 srst = 1'b0;
        @(negedge clk);
        check("awvalid after reset", 0, 32'(awvalid));
        check("wvalid after reset", 0, 32'(wvalid));
        check("arvalid after reset", 0, 32'(arvalid));
        check("wr_ack after reset", 0, 32'(wr_ack));
        check("rd_ack after reset", 0, 32'(rd_ack));
        repeat (3) @(posedge clk);
        #2;
        issue(1'b1, N_WR);
        wait (w_beats == N_WR && aw_q.size() == 0);
        @(posedge clk);
        #2;
        issue(1'b0, N_RD);
        wait (r_beats == N_RD && ar_q.size() == 0);
        repeat (5) @(posedge clk);
        check("write acks", wr_accepted, ack_count);
        check("read acks", rd_accepted, rd_ack_count);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/axi_read_channel.sv */
/*
 * AXI3 read channels
 * Issues AR from the head context and registers R beats for the controller
 */
`timescale 1ns/1ns
`include "bridge_params.svh"

module axi_read_channel (
    input  logic                    clk,
    input  logic                    srst,
    input  logic                    ctxt_vld,
    input  bridge_pkg::burst_ctxt_t ctxt,
    output logic                    ctxt_pop,
    output logic                    arvalid,
    input  logic                    arready,
    output bridge_pkg::axi_addr_t   araddr,
    output bridge_pkg::burst_len_t  arlen,
    input  logic                    rvalid,
    input  bridge_pkg::data_t       rdata,
    input  logic                    rlast,
    output logic                    rd_ack,
    output bridge_pkg::data_t       rd_data
);
    // Enough for every queued context to be in flight at once
    localparam int OUT_WID = $clog2(`BRIDGE_CTXT_DEPTH) + 2;

    logic                   ar_xfer;
    logic                   r_done;
    logic [OUT_WID-1:0]     bursts_out;
    bridge_pkg::burst_len_t last_arlen;
    bridge_pkg::burst_len_t beat_cnt;

    assign ar_xfer  = arvalid && arready;
    assign r_done   = rvalid && rlast;

    assign arvalid  = ctxt_vld;
    assign araddr   = bridge_pkg::ctxt_byte_addr(ctxt);
    assign arlen    = bridge_pkg::ctxt_len(ctxt);
    assign ctxt_pop = ar_xfer;

    // ----------------------------------------
    // Read return, one register stage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rvalid;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= rdata;
    end

    // ----------------------------------------
    // Burst tracking
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            bursts_out <= '0;
            beat_cnt   <= '0;
        end else begin
            bursts_out <= bursts_out + OUT_WID'(ar_xfer) - OUT_WID'(r_done);
            if (r_done) begin
                beat_cnt <= '0;
            end else if (rvalid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_xfer) begin
            last_arlen <= arlen;
        end
    end

    a_r_expected: assert property (@(posedge clk) disable iff (srst)
        rvalid |-> bursts_out != '0);

    // With one burst outstanding its length is the last one issued
    a_rlast_len: assert property (@(posedge clk) disable iff (srst)
        rvalid && bursts_out == OUT_WID'(1) |-> rlast == (beat_cnt == last_arlen));

endmodule

/* source/axi_write_channel.sv */
/*
 * AXI3 write address and data channels
 * One AW per burst context, then its W beats with wlast on the final one
 */
`timescale 1ns/1ns

module axi_write_channel (
    input  logic                    clk,
    input  logic                    srst,
    input  logic                    ctxt_vld,
    input  bridge_pkg::burst_ctxt_t ctxt,
    output logic                    ctxt_pop,
    input  logic                    data_vld,
    output logic                    data_pop,
    output logic                    awvalid,
    input  logic                    awready,
    output bridge_pkg::axi_addr_t   awaddr,
    output bridge_pkg::burst_len_t  awlen,
    output logic                    wvalid,
    input  logic                    wready,
    output logic                    wlast,
    output logic                    beat_done
);
    logic                   sop;
    logic                   aw_xfer;
    logic                   w_xfer;
    bridge_pkg::burst_len_t awlen_q;
    bridge_pkg::burst_len_t beat_cnt;

    assign aw_xfer = awvalid && awready;
    assign w_xfer  = wvalid && wready;

    // AW goes out at start of burst
    assign awvalid  = sop && ctxt_vld;
    assign awaddr   = bridge_pkg::ctxt_byte_addr(ctxt);
    assign awlen    = bridge_pkg::ctxt_len(ctxt);
    assign ctxt_pop = aw_xfer;

    // W beats follow once the burst's AW is taken
    assign wvalid    = data_vld && !sop;
    assign wlast     = (beat_cnt == awlen_q);
    assign data_pop  = w_xfer;
    assign beat_done = w_xfer;

    always_ff @(posedge clk) begin
        if (srst) begin
            sop      <= 1'b1;
            beat_cnt <= '0;
        end else if (aw_xfer) begin
            sop      <= 1'b0;
            beat_cnt <= '0;
        end else if (w_xfer) begin
            sop      <= wlast;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Length of the burst in progress
    always_ff @(posedge clk) begin
        if (aw_xfer) begin
            awlen_q <= awlen;
        end
    end

    a_wvalid_hold: assert property (@(posedge clk) disable iff (srst)
        wvalid && !wready |=> wvalid);

endmodule

/* source/bridge_params.svh */
/*
 * Memory to AXI3 bridge parameters
 * Widths, queue depths, burst limit and AXI base address
 */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// Controller side
`define BRIDGE_WORD_ADDR_WID 10
`define BRIDGE_DATA_WID      32
`define BRIDGE_BYTE_SEL_WID  2

// AXI3 side
`define BRIDGE_AXI_ADDR_WID  32
`define BRIDGE_BURST_LEN_WID 4
`define BRIDGE_MAX_BURST     16
`define BRIDGE_BASE_ADDR     32'h4000_0000

// Queue depths
`define BRIDGE_CTXT_DEPTH    32
`define BRIDGE_WDATA_DEPTH   16

`endif

/* source/bridge_pkg.sv */
/*
 * Bridge types
 * Vector typedefs, burst FSM states and burst context field helpers
 */
`include "bridge_params.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_WORD_ADDR_WID-1:0] word_addr_t;
    typedef logic [`BRIDGE_DATA_WID-1:0]      data_t;
    typedef logic [`BRIDGE_BURST_LEN_WID-1:0] burst_len_t;
    typedef logic [`BRIDGE_AXI_ADDR_WID-1:0]  axi_addr_t;

    // Start word address on top, AXI length (beats minus one) below
    typedef logic [`BRIDGE_WORD_ADDR_WID+`BRIDGE_BURST_LEN_WID-1:0] burst_ctxt_t;

    typedef enum logic [1:0] {
        st_reset,
        st_burst_start,
        st_in_burst
    } burst_state_t;

    function automatic burst_len_t ctxt_len(burst_ctxt_t ctxt);
        return ctxt[`BRIDGE_BURST_LEN_WID-1:0];
    endfunction

    // Base plus word address scaled to bytes
    function automatic axi_addr_t ctxt_byte_addr(burst_ctxt_t ctxt);
        axi_addr_t word_addr;
        word_addr = axi_addr_t'(ctxt[`BRIDGE_BURST_LEN_WID +: `BRIDGE_WORD_ADDR_WID]);
        return axi_addr_t'(`BRIDGE_BASE_ADDR) + (word_addr << `BRIDGE_BYTE_SEL_WID);
    endfunction

endpackage

/* source/burst_ctrl.sv */
/*
 * Burst grouping control
 * Folds runs of consecutive word requests into AXI burst contexts
 * for the write and the read path
 */
`timescale 1ns/1ns
`include "bridge_params.svh"

module burst_ctrl (
    input  logic                    clk,
    input  logic                    srst,
    mem_req_if.bridge               mem_wr,
    mem_req_if.bridge               mem_rd,
    input  logic                    wr_data_rdy,
    input  logic                    rd_ctxt_rdy,
    output logic                    wr_ctxt_push,
    output logic                    rd_ctxt_push,
    output bridge_pkg::burst_ctxt_t wr_ctxt,
    output bridge_pkg::burst_ctxt_t rd_ctxt
);
    localparam bridge_pkg::burst_len_t LAST_LEN =
        bridge_pkg::burst_len_t'(`BRIDGE_MAX_BURST - 1);

    // Index 0 is the write path, index 1 the read path
    logic                    acc [2];
    bridge_pkg::word_addr_t  addr_in [2];
    logic                    push [2];
    bridge_pkg::burst_ctxt_t ctxt [2];

    // ----------------------------------------
    // Request acceptance
    // ----------------------------------------
    assign mem_wr.rdy = wr_data_rdy;
    assign mem_rd.rdy = rd_ctxt_rdy;

    assign acc[0]     = mem_wr.req && mem_wr.en && mem_wr.rdy;
    assign acc[1]     = mem_rd.req && mem_rd.rdy;
    assign addr_in[0] = mem_wr.addr;
    assign addr_in[1] = mem_rd.addr;

    // ----------------------------------------
    // Grouping FSM, one per path
    // ----------------------------------------
    for (genvar i = 0; i < 2; i++) begin : g_path
        bridge_pkg::burst_state_t state;
        bridge_pkg::burst_state_t state_nxt;
        logic                     load;
        logic                     extend;
        logic                     done;
        bridge_pkg::word_addr_t   start_addr;
        bridge_pkg::word_addr_t   next_addr;
        bridge_pkg::burst_len_t   len;

        always_ff @(posedge clk) begin
            if (srst) begin
                state <= bridge_pkg::st_reset;
            end else begin
                state <= state_nxt;
            end
        end

        always_comb begin
            state_nxt = state;
            load      = 1'b0;
            extend    = 1'b0;
            done      = 1'b0;
            case (state)
                bridge_pkg::st_burst_start: begin
                    // Follow the request address until one is taken
                    load = 1'b1;
                    if (acc[i]) begin
                        state_nxt = bridge_pkg::st_in_burst;
                    end
                end
                bridge_pkg::st_in_burst: begin
                    if (!acc[i]) begin
                        done      = 1'b1;
                        load      = 1'b1;
                        state_nxt = bridge_pkg::st_burst_start;
                    end else if (addr_in[i] == next_addr && len != LAST_LEN) begin
                        extend = 1'b1;
                    end else begin
                        // Run broken or full, this request opens the next one
                        done = 1'b1;
                        load = 1'b1;
                    end
                end
                default: begin
                    state_nxt = bridge_pkg::st_burst_start;
                end
            endcase
        end

        always_ff @(posedge clk) begin
            if (load) begin
                start_addr <= addr_in[i];
                next_addr  <= addr_in[i] + 1'b1;
                len        <= '0;
            end else if (extend) begin
                next_addr <= next_addr + 1'b1;
                len       <= len + 1'b1;
            end
        end

        assign push[i] = done;
        assign ctxt[i] = {start_addr, len};
    end

    assign wr_ctxt_push = push[0];
    assign rd_ctxt_push = push[1];
    assign wr_ctxt      = ctxt[0];
    assign rd_ctxt      = ctxt[1];

    // Every accepted write lands in a context within one full burst time
    a_wr_closed: assert property (@(posedge clk) disable iff (srst)
        acc[0] |=> ##[0:`BRIDGE_MAX_BURST-1] wr_ctxt_push);

endmodule

/* source/burst_fifo.sv */
/*
 * Synchronous FIFO
 * Circular buffer with read and write pointers and an occupancy count
 */
`timescale 1ns/1ns

module burst_fifo #(
    parameter int DATA_WID = 32,
    parameter int DEPTH    = 16
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data
);
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [PTR_WID-1:0]  wr_ptr;
    logic [PTR_WID-1:0]  rd_ptr;
    logic [CNT_WID-1:0]  count;

    // Last entry held back from wr_rdy. A producer that still owes one
    // push after rdy falls always finds room for it
    assign wr_rdy  = (count < CNT_WID'(DEPTH - 1));
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (srst)
        wr |-> count != CNT_WID'(DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (srst)
        rd |-> rd_vld);

endmodule

/* source/mem_axi3_bridge.sv */
/*
 * Memory to AXI3 bridge
 * Groups word requests into INCR bursts on AW, W and AR and
 * returns read beats to the controller
 */
`timescale 1ns/1ns
`include "bridge_params.svh"

module mem_axi3_bridge (
    input  logic                   clk,
    input  logic                   srst,
    // Controller write port
    input  logic                   wr_req,
    input  logic                   wr_en,
    input  bridge_pkg::word_addr_t wr_addr,
    input  bridge_pkg::data_t      wr_data,
    output logic                   wr_rdy,
    output logic                   wr_ack,
    // Controller read port
    input  logic                   rd_req,
    input  bridge_pkg::word_addr_t rd_addr,
    output logic                   rd_rdy,
    output logic                   rd_ack,
    output bridge_pkg::data_t      rd_data,
    // AXI3 write
    output logic                   awvalid,
    input  logic                   awready,
    output bridge_pkg::axi_addr_t  awaddr,
    output bridge_pkg::burst_len_t awlen,
    output logic                   wvalid,
    input  logic                   wready,
    output bridge_pkg::data_t      wdata,
    output logic                   wlast,
    // AXI3 read
    output logic                   arvalid,
    input  logic                   arready,
    output bridge_pkg::axi_addr_t  araddr,
    output bridge_pkg::burst_len_t arlen,
    input  logic                   rvalid,
    input  bridge_pkg::data_t      rdata,
    input  logic                   rlast
);
    logic                    wr_data_rdy;
    logic                    wr_data_vld;
    logic                    wr_data_pop;
    logic                    wr_ctxt_push;
    logic                    wr_ctxt_vld;
    logic                    wr_ctxt_pop;
    logic                    wr_beat_done;
    logic                    rd_ctxt_rdy;
    logic                    rd_ctxt_push;
    logic                    rd_ctxt_vld;
    logic                    rd_ctxt_pop;
    logic                    rd_beat_ack;
    bridge_pkg::burst_ctxt_t wr_ctxt_in;
    bridge_pkg::burst_ctxt_t wr_ctxt_head;
    bridge_pkg::burst_ctxt_t rd_ctxt_in;
    bridge_pkg::burst_ctxt_t rd_ctxt_head;

    mem_req_if wr_if ();
    mem_req_if rd_if ();

    // ----------------------------------------
    // Controller ports
    // ----------------------------------------
    assign wr_if.req  = wr_req;
    assign wr_if.en   = wr_en;
    assign wr_if.addr = wr_addr;
    assign wr_if.data = wr_data;
    assign wr_if.ack  = wr_beat_done;
    assign wr_rdy     = wr_if.rdy;
    assign wr_ack     = wr_if.ack;

    // Reads carry no enable and no write data
    assign rd_if.req  = rd_req;
    assign rd_if.addr = rd_addr;
    assign rd_if.ack  = rd_beat_ack;
    assign rd_rdy     = rd_if.rdy;
    assign rd_ack     = rd_if.ack;

    burst_ctrl u_burst_ctrl (
        .clk          (clk),
        .srst         (srst),
        .mem_wr       (wr_if),
        .mem_rd       (rd_if),
        .wr_data_rdy  (wr_data_rdy),
        .rd_ctxt_rdy  (rd_ctxt_rdy),
        .wr_ctxt_push (wr_ctxt_push),
        .rd_ctxt_push (rd_ctxt_push),
        .wr_ctxt      (wr_ctxt_in),
        .rd_ctxt      (rd_ctxt_in)
    );

    // ----------------------------------------
    // Queues
    // ----------------------------------------
    // One extra entry so rdy falls with 16 beats queued
    burst_fifo #(
        .DATA_WID ($bits(bridge_pkg::data_t)),
        .DEPTH    (`BRIDGE_WDATA_DEPTH + 1)
    ) u_wdata_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (wr_if.req && wr_if.en && wr_if.rdy),
        .wr_data (wr_if.data),
        .wr_rdy  (wr_data_rdy),
        .rd      (wr_data_pop),
        .rd_vld  (wr_data_vld),
        .rd_data (wdata)
    );

    // Bounded by the data queue, never fills
    burst_fifo #(
        .DATA_WID ($bits(bridge_pkg::burst_ctxt_t)),
        .DEPTH    (`BRIDGE_CTXT_DEPTH)
    ) u_wr_ctxt_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (wr_ctxt_push),
        .wr_data (wr_ctxt_in),
        .wr_rdy  (),
        .rd      (wr_ctxt_pop),
        .rd_vld  (wr_ctxt_vld),
        .rd_data (wr_ctxt_head)
    );

    // Spare entry takes the burst still open when rdy falls
    burst_fifo #(
        .DATA_WID ($bits(bridge_pkg::burst_ctxt_t)),
        .DEPTH    (`BRIDGE_CTXT_DEPTH + 1)
    ) u_rd_ctxt_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (rd_ctxt_push),
        .wr_data (rd_ctxt_in),
        .wr_rdy  (rd_ctxt_rdy),
        .rd      (rd_ctxt_pop),
        .rd_vld  (rd_ctxt_vld),
        .rd_data (rd_ctxt_head)
    );

    // ----------------------------------------
    // AXI3 channels
    // ----------------------------------------
    axi_write_channel u_axi_write (
        .clk       (clk),
        .srst      (srst),
        .ctxt_vld  (wr_ctxt_vld),
        .ctxt      (wr_ctxt_head),
        .ctxt_pop  (wr_ctxt_pop),
        .data_vld  (wr_data_vld),
        .data_pop  (wr_data_pop),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .wvalid    (wvalid),
        .wready    (wready),
        .wlast     (wlast),
        .beat_done (wr_beat_done)
    );

    axi_read_channel u_axi_read (
        .clk      (clk),
        .srst     (srst),
        .ctxt_vld (rd_ctxt_vld),
        .ctxt     (rd_ctxt_head),
        .ctxt_pop (rd_ctxt_pop),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arlen    (arlen),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rlast    (rlast),
        .rd_ack   (rd_beat_ack),
        .rd_data  (rd_data)
    );

endmodule

/* source/mem_req_if.sv */
/*
 * Memory request port
 * Strobe-based request bundle between controller and bridge
 */
`timescale 1ns/1ns

interface mem_req_if;
    logic                   req;
    logic                   en;
    logic                   rdy;
    bridge_pkg::word_addr_t addr;
    bridge_pkg::data_t      data;
    logic                   ack;

    // Request side
    modport controller (
        output req,
        output en,
        output addr,
        output data,
        input  rdy,
        input  ack
    );

    // Accepting side
    modport bridge (
        input  req,
        input  en,
        input  addr,
        input  data,
        output rdy,
        output ack
    );
endinterface
